// File: src.f
+incdir+design
design/fat_pkg.sv
design/fat_block_reader.sv
design/fat_boot_decode.sv
design/fat_dir_scan.sv
design/fat_entry_out.sv
design/fat_mount_ctrl.sv
design/fat_reader_top.sv
bench/fat_reader_checker.sv
bench/fat_reader_tb.sv

// File: Bender.yml
package:
  name: fat_reader

sources:
  - include_dirs:
      - design
    files:
      - design/fat_pkg.sv
      - design/fat_block_reader.sv
      - design/fat_boot_decode.sv
      - design/fat_dir_scan.sv
      - design/fat_entry_out.sv
      - design/fat_mount_ctrl.sv
      - design/fat_reader_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/fat_reader_checker.sv
      - bench/fat_reader_tb.sv

// File: bench/fat_reader_tb.sv
//********************
// FAT16 mount engine testbench
// SD card and sector buffer model, reference mount, entry compare
//********************
`default_nettype none

`include "fat_consts.svh"

module fat_reader_tb;
	import fat_pkg::*;

	localparam int CLK_PERIOD    = 10;
	localparam int IMG_SECTORS   = 64;
	localparam int NUM_MOUNTS    = 9;
	localparam int MOUNT_CYCLES  = 33 * 40 + 16 * 600;
	localparam int WATCHDOG_TIME = (NUM_MOUNTS * MOUNT_CYCLES + 1000) * CLK_PERIOD;

	logic        sys_clk;
	logic        rst;
	logic        mount_req;
	logic        sd_idle;
	byte_t       buf_rd_data;
	logic        block_req;
	block_addr_t block_addr;
	buf_addr_t   buf_rd_addr;
	logic        entry_valid;
	dir_entry_t  entry;
	logic        mount_busy;
	logic        mount_done;
	mount_err_e  mount_err;
	file_count_t file_count;

	byte_t       disk [IMG_SECTORS][`FAT_SECTOR_BYTES];
	byte_t       sector_buf [`FAT_SECTOR_BYTES];
	buf_addr_t   addr_d;
	int          busy_cnt;
	int          root_sec;
	int          done_count;

	dir_entry_t  exp_entries[$];
	block_addr_t exp_blocks[$];
	mount_err_e  exp_err;
	file_count_t exp_count;

	fat_reader_top i_fat_reader_top (
		.sys_clk(sys_clk), .rst(rst), .mount_req(mount_req), .sd_idle(sd_idle),
		.buf_rd_data(buf_rd_data), .block_req(block_req), .block_addr(block_addr),
		.buf_rd_addr(buf_rd_addr), .entry_valid(entry_valid), .entry(entry),
		.mount_busy(mount_busy), .mount_done(mount_done), .mount_err(mount_err),
		.file_count(file_count)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped on first failure");
	endtask

	task automatic verify_entry(input dir_entry_t got, input dir_entry_t exp);
		if (got !== exp)
			stop_run($sformatf({"** Error at time %0t: entry idx %0d name %h clus %h size %h,",
				" expected idx %0d name %h clus %h size %h"}, $time, got.idx, got.name,
				got.first_clus, got.size, exp.idx, exp.name, exp.first_clus, exp.size));
	endtask

	task automatic compare_err(input mount_err_e got, input mount_err_e exp);
		if (got !== exp)
			stop_run($sformatf("** Error at time %0t: mount_err %0d, expected %0d",
				$time, got, exp));
	endtask

	task automatic match_count(input file_count_t got, input file_count_t exp);
		if (got !== exp)
			stop_run($sformatf("** Error at time %0t: file_count %0d, expected %0d",
				$time, got, exp));
	endtask

	task automatic expect_block(input block_addr_t got, input block_addr_t exp);
		if (got !== exp)
			stop_run($sformatf("** Error at time %0t: block_addr %0d, expected %0d",
				$time, got, exp));
	endtask

	// expected error, entries and block sequence straight from the image
	function automatic mount_err_e predict_mount();
		logic [15:0] bps;
		logic [15:0] rsvd;
		logic [15:0] root_ent;
		logic [15:0] fat_sz;
		int          base;
		int          sec;
		int          ofs;
		byte_t       first;
		byte_t       attr;
		logic        stop;
		dir_entry_t  e;
		exp_entries.delete();
		exp_blocks.delete();
		exp_count = '0;
		exp_blocks.push_back('0);
		bps = {disk[0][`FAT_OFS_BYTES_PER_SEC + 1], disk[0][`FAT_OFS_BYTES_PER_SEC]};
		rsvd = {disk[0][`FAT_OFS_RSVD_SEC + 1], disk[0][`FAT_OFS_RSVD_SEC]};
		root_ent = {disk[0][`FAT_OFS_ROOT_ENT + 1], disk[0][`FAT_OFS_ROOT_ENT]};
		fat_sz = {disk[0][`FAT_OFS_FAT_SIZE + 1], disk[0][`FAT_OFS_FAT_SIZE]};
		if (bps != `FAT_SECTOR_BYTES)
			return ERR_SECTOR_SIZE;
		if (fat_sz == 0)
			return ERR_NOT_FAT16;
		if (root_ent != `FAT_ROOT_ENTRIES)
			return ERR_ROOT_SIZE;
		base = rsvd + 2 * fat_sz;
		stop = 1'b0;
		for (int s = 0; s < `FAT_ROOT_SECTORS && !stop; s++)
		begin
			exp_blocks.push_back(block_addr_t'(base + s));
			sec = (base + s) % IMG_SECTORS;
			for (int k = 0; k < 16 && !stop; k++)
			begin
				ofs = k * `FAT_ENTRY_BYTES;
				first = disk[sec][ofs];
				attr = disk[sec][ofs + `FAT_OFS_ATTR];
				if (first == `FAT_ENTRY_END)
					stop = 1'b1;
				else if (first != `FAT_ENTRY_DELETED && attr[5:0] != 6'h0F
					&& !attr[3] && !attr[4])
				begin
					e.idx = file_idx_t'(exp_count);
					for (int i = 0; i < `FAT_NAME_BYTES; i++)
						e.name[i] = disk[sec][ofs + i];
					e.first_clus = {disk[sec][ofs + 27], disk[sec][ofs + 26]};
					e.size = {disk[sec][ofs + 31], disk[sec][ofs + 30],
						disk[sec][ofs + 29], disk[sec][ofs + 28]};
					exp_entries.push_back(e);
					exp_count = exp_count + 5'd1;
					if (exp_count == `FAT_MAX_FILES)
						stop = 1'b1;
				end
			end
		end
		return ERR_NONE;
	endfunction

	task automatic fill_image();
		int flat;
		for (int s = 0; s < IMG_SECTORS; s++)
			for (int o = 0; o < `FAT_SECTOR_BYTES; o++)
			begin
				flat = s * `FAT_SECTOR_BYTES + o;
				disk[s][o] = byte_t'(flat ^ (flat >> 8) ^ 8'h5A);
			end
	endtask

	// boot fields, then a clean root directory
	task automatic set_boot(input logic [15:0] bps, input logic [15:0] rsvd,
		input logic [15:0] fat_sz, input logic [15:0] root_ent);
		disk[0][`FAT_OFS_BYTES_PER_SEC] = bps[7:0];
		disk[0][`FAT_OFS_BYTES_PER_SEC + 1] = bps[15:8];
		disk[0][`FAT_OFS_SEC_PER_CLUS] = 8'd4;
		disk[0][`FAT_OFS_RSVD_SEC] = rsvd[7:0];
		disk[0][`FAT_OFS_RSVD_SEC + 1] = rsvd[15:8];
		disk[0][`FAT_OFS_ROOT_ENT] = root_ent[7:0];
		disk[0][`FAT_OFS_ROOT_ENT + 1] = root_ent[15:8];
		disk[0][`FAT_OFS_FAT_SIZE] = fat_sz[7:0];
		disk[0][`FAT_OFS_FAT_SIZE + 1] = fat_sz[15:8];
		root_sec = rsvd + 2 * fat_sz;
		for (int s = root_sec; s < root_sec + `FAT_ROOT_SECTORS && s < IMG_SECTORS; s++)
			for (int o = 0; o < `FAT_SECTOR_BYTES; o++)
				disk[s][o] = '0;
	endtask

	task automatic put_file(input int slot, input byte_t attr, input int id);
		int          sec;
		int          ofs;
		logic [15:0] clus;
		logic [31:0] size;
		sec = root_sec + slot / 16;
		ofs = (slot % 16) * `FAT_ENTRY_BYTES;
		clus = 16'(16'h0100 + id * 3);
		size = 32'(id * 32'h0102_0305 + 17);
		for (int i = 0; i < 8; i++)
			disk[sec][ofs + i] = byte_t'(8'h41 + (id + i) % 26);
		disk[sec][ofs + 8] = 8'h54;
		disk[sec][ofs + 9] = byte_t'(8'h30 + id % 10);
		disk[sec][ofs + 10] = 8'h54;
		disk[sec][ofs + `FAT_OFS_ATTR] = attr;
		disk[sec][ofs + 26] = clus[7:0];
		disk[sec][ofs + 27] = clus[15:8];
		for (int i = 0; i < 4; i++)
			disk[sec][ofs + 28 + i] = size[8*i +: 8];
	endtask

	task automatic mark_deleted(input int slot);
		disk[root_sec + slot / 16][(slot % 16) * `FAT_ENTRY_BYTES] = `FAT_ENTRY_DELETED;
	endtask

	task automatic run_mount(input string name);
		int start_done;
		int cycles;
		exp_err = predict_mount();
		start_done = done_count;
		@(posedge sys_clk);
		#1 mount_req = 1'b1;
		@(posedge sys_clk);
		#1 mount_req = 1'b0;
		if (!mount_busy)
			stop_run($sformatf("mount_busy did not rise for mount '%s'", name));
		cycles = 0;
		while (done_count == start_done && cycles < MOUNT_CYCLES)
		begin
			@(posedge sys_clk);
			cycles++;
		end
		if (done_count == start_done)
			stop_run($sformatf("mount '%s' never signalled mount_done", name));
		repeat (2) @(posedge sys_clk);
		#1;
		if (mount_busy)
			stop_run($sformatf("mount_busy stayed high after mount '%s'", name));
	endtask

	// SD card: sector load on request, busy time, one cycle read latency
	always @(posedge sys_clk)
	begin
		#1;
		buf_rd_data = sector_buf[addr_d];
		addr_d = buf_rd_addr;
		if (block_req === 1'b1)
		begin
			if (exp_blocks.size() == 0)
				stop_run($sformatf("unexpected block request for block %0d", block_addr));
			else
				expect_block(block_addr, exp_blocks.pop_front());
			for (int o = 0; o < `FAT_SECTOR_BYTES; o++)
				sector_buf[o] = disk[block_addr % IMG_SECTORS][o];
			busy_cnt = 5 + $urandom % 16;
			sd_idle = 1'b0;
		end
		else if (busy_cnt != 0)
		begin
			busy_cnt--;
			if (busy_cnt == 0)
				sd_idle = 1'b1;
		end
	end

	always @(negedge sys_clk)
	begin
		if (!rst)
		begin
			if (i_fat_reader_top.i_fat_reader_checker.fail_count != 0)
				stop_run("a protocol assertion on the DUT failed");
			if (entry_valid)
			begin
				if (exp_entries.size() == 0)
					stop_run($sformatf("unexpected entry with idx %0d reported", entry.idx));
				else
					verify_entry(entry, exp_entries.pop_front());
			end
			if (mount_done)
			begin
				compare_err(mount_err, exp_err);
				match_count(file_count, exp_count);
				if (exp_entries.size() != 0)
					stop_run($sformatf("%0d expected entries were never reported",
						exp_entries.size()));
				else if (exp_blocks.size() != 0)
					stop_run("the mount ended before all expected block requests");
				else
					done_count++;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_TIME);
		stop_run("watchdog expired, the run timed out");
	end

	initial
	begin
		sys_clk = 1'b0;
		rst = 1'b1;
		mount_req = 1'b0;
		sd_idle = 1'b1;
		buf_rd_data = '0;
		addr_d = '0;
		busy_cnt = 0;
		done_count = 0;
		root_sec = 0;
		void'($urandom(20154));
		repeat (10) @(posedge sys_clk);
		#1 rst = 1'b0;

		// regular files among skipped slot types, file after the end marker
		fill_image();
		set_boot(16'd512, 16'd1, 16'd2, 16'd512);
		put_file(0, 8'h20, 1);
		put_file(1, 8'h20, 2);
		mark_deleted(1);
		put_file(2, 8'h0F, 3);
		put_file(3, 8'h08, 4);
		put_file(4, 8'h10, 5);
		put_file(5, 8'h00, 6);
		put_file(6, 8'h01, 7);
		put_file(7, 8'h4F, 8);
		put_file(8, 8'h22, 9);
		put_file(10, 8'h20, 10);
		run_mount("mixed slots");

		fill_image();
		set_boot(16'd1024, 16'd1, 16'd2, 16'd512);
		run_mount("bad sector size");
		fill_image();
		set_boot(16'd512, 16'd1, 16'd0, 16'd512);
		run_mount("zero fat size");
		fill_image();
		set_boot(16'd512, 16'd1, 16'd2, 16'd256);
		run_mount("bad root size");
		fill_image();
		set_boot(16'd256, 16'd1, 16'd0, 16'd16);
		run_mount("all checks broken");

		// files continue into the second root sector, mounted twice
		fill_image();
		set_boot(16'd512, 16'd4, 16'd3, 16'd512);
		for (int i = 0; i < 10; i++)
			put_file(i, 8'h20, 20 + i);
		for (int i = 10; i < 16; i++)
			put_file(i, (i % 2 == 0) ? 8'h10 : 8'h20, 40 + i);
		for (int i = 11; i < 16; i += 2)
			mark_deleted(i);
		for (int i = 16; i < 20; i++)
			put_file(i, 8'h00, 60 + i);
		run_mount("two sectors");
		run_mount("two sectors again");

		// more than 16 regular files
		fill_image();
		set_boot(16'd512, 16'd2, 16'd5, 16'd512);
		for (int i = 0; i < 28; i++)
			put_file(i, 8'h20, 100 + i);
		for (int i = 12; i < 16; i++)
			mark_deleted(i);
		run_mount("file limit");

		// walk through all root sectors to the very last slot
		fill_image();
		set_boot(16'd512, 16'd1, 16'd1, 16'd512);
		for (int i = 0; i < `FAT_ROOT_ENTRIES - 1; i++)
			mark_deleted(i);
		put_file(`FAT_ROOT_ENTRIES - 1, 8'h20, 90);
		run_mount("full root walk");

		if (i_fat_reader_top.i_fat_reader_checker.fail_count != 0)
			stop_run("a protocol assertion on the DUT failed");
		else
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: bench/fat_reader_checker.sv
//********************
// mount engine protocol checker
// bound to the top level
//********************
`default_nettype none

`include "fat_consts.svh"

module fat_reader_checker (
	input  wire                 sys_clk,
	input  wire                 rst,
	input  logic                block_req,
	input  logic                mount_done,
	input  logic                mount_busy,
	input  logic                entry_valid,
	input  fat_pkg::dir_entry_t entry
);
	import fat_pkg::*;

	int         fail_count = 0; // polled by the testbench
	logic [4:0] seen_cnt;

	// entries reported so far in this mount
	always_ff @(posedge sys_clk)
	begin
		if (rst || !mount_busy)
			seen_cnt <= '0;
		else if (entry_valid)
			seen_cnt <= seen_cnt + 5'd1;
	end

	a_req_pulse: assert property (@(posedge sys_clk) disable iff (rst)
		block_req |=> !block_req)
	else
	begin
		fail_count++;
		$error("block_req high for two cycles");
	end

	a_done_pulse: assert property (@(posedge sys_clk) disable iff (rst)
		mount_done |=> !mount_done)
	else
	begin
		fail_count++;
		$error("mount_done longer than one cycle");
	end

	a_entry_busy: assert property (@(posedge sys_clk) disable iff (rst)
		entry_valid |-> mount_busy)
	else
	begin
		fail_count++;
		$error("entry_valid outside a mount");
	end

	a_entry_idx: assert property (@(posedge sys_clk) disable iff (rst)
		entry_valid |-> (32'(seen_cnt) < `FAT_MAX_FILES) && (entry.idx == seen_cnt[3:0]))
	else
	begin
		fail_count++;
		$error("entry index out of range or out of order");
	end

endmodule

bind fat_reader_top fat_reader_checker i_fat_reader_checker (
	.sys_clk(sys_clk), .rst(rst), .block_req(block_req), .mount_done(mount_done),
	.mount_busy(mount_busy), .entry_valid(entry_valid), .entry(entry)
);

`default_nettype wire

// File: design/fat_reader_top.sv
//********************
// FAT16 mount engine
// mounts the card and lists root directory files
//********************
`default_nettype none

module fat_reader_top (
	input  wire                   sys_clk,
	input  wire                   rst,
	input  logic                  mount_req,
	input  logic                  sd_idle,
	input  fat_pkg::byte_t        buf_rd_data,
	output logic                  block_req,
	output fat_pkg::block_addr_t  block_addr,
	output fat_pkg::buf_addr_t    buf_rd_addr,
	output logic                  entry_valid,
	output fat_pkg::dir_entry_t   entry,
	output logic                  mount_busy,
	output logic                  mount_done,
	output fat_pkg::mount_err_e   mount_err,
	output fat_pkg::file_count_t  file_count
);
	import fat_pkg::*;

	logic        boot_go, scan_go, clear;
	logic        boot_done, scan_done, blk_done;
	logic        blk_start, boot_blk_start, scan_blk_start;
	block_addr_t blk_addr, boot_blk_addr, scan_blk_addr;
	buf_addr_t   boot_rd_addr, scan_rd_addr;
	bpb_t        bpb;
	mount_err_e  boot_err;
	logic        full, hit;
	dir_entry_t  hit_entry;

	fat_mount_ctrl i_mount_ctrl (
		.sys_clk(sys_clk), .rst(rst), .mount_req(mount_req), .sd_idle(sd_idle),
		.boot_done(boot_done), .boot_err(boot_err), .scan_done(scan_done),
		.boot_go(boot_go), .scan_go(scan_go), .clear(clear),
		.boot_blk_start(boot_blk_start), .boot_blk_addr(boot_blk_addr),
		.boot_rd_addr(boot_rd_addr), .scan_blk_start(scan_blk_start),
		.scan_blk_addr(scan_blk_addr), .scan_rd_addr(scan_rd_addr),
		.blk_start(blk_start), .blk_addr(blk_addr), .rd_addr(buf_rd_addr),
		.mount_busy(mount_busy), .mount_done(mount_done), .mount_err(mount_err)
	);

	fat_block_reader i_block_reader (
		.sys_clk(sys_clk), .rst(rst), .blk_start(blk_start), .blk_addr(blk_addr),
		.sd_idle(sd_idle), .block_req(block_req), .block_addr(block_addr),
		.blk_done(blk_done)
	);

	fat_boot_decode i_boot_decode (
		.sys_clk(sys_clk), .rst(rst), .go(boot_go), .rd_addr(boot_rd_addr),
		.rd_data(buf_rd_data), .blk_start(boot_blk_start), .blk_addr(boot_blk_addr),
		.blk_done(blk_done), .bpb(bpb), .boot_err(boot_err), .boot_done(boot_done)
	);

	fat_dir_scan i_dir_scan (
		.sys_clk(sys_clk), .rst(rst), .go(scan_go), .bpb(bpb), .rd_addr(scan_rd_addr),
		.rd_data(buf_rd_data), .blk_start(scan_blk_start), .blk_addr(scan_blk_addr),
		.blk_done(blk_done), .full(full), .hit(hit), .hit_entry(hit_entry),
		.scan_done(scan_done)
	);

	fat_entry_out i_entry_out (
		.sys_clk(sys_clk), .rst(rst), .clear(clear), .hit(hit), .hit_entry(hit_entry),
		.entry_valid(entry_valid), .entry(entry), .full(full), .file_count(file_count)
	);

endmodule

`default_nettype wire

// File: design/fat_mount_ctrl.sv
//********************
// mount sequencer
// card wait, boot decode, directory scan and final report
//********************
`default_nettype none

module fat_mount_ctrl (
	input  wire                  sys_clk,
	input  wire                  rst,
	input  logic                 mount_req,
	input  logic                 sd_idle,
	input  logic                 boot_done,
	input  fat_pkg::mount_err_e  boot_err,
	input  logic                 scan_done,
	output logic                 boot_go,
	output logic                 scan_go,
	output logic                 clear,
	input  logic                 boot_blk_start,
	input  fat_pkg::block_addr_t boot_blk_addr,
	input  fat_pkg::buf_addr_t   boot_rd_addr,
	input  logic                 scan_blk_start,
	input  fat_pkg::block_addr_t scan_blk_addr,
	input  fat_pkg::buf_addr_t   scan_rd_addr,
	output logic                 blk_start,
	output fat_pkg::block_addr_t blk_addr,
	output fat_pkg::buf_addr_t   rd_addr,
	output logic                 mount_busy,
	output logic                 mount_done,
	output fat_pkg::mount_err_e  mount_err
);
	import fat_pkg::*;

	mount_state_e state;

	// only the active client reaches the reader and buffer
	always_comb
	begin
		blk_start = 1'b0;
		blk_addr = '0;
		rd_addr = '0;
		case (state)
			MNT_BOOT:
			begin
				blk_start = boot_blk_start;
				blk_addr = boot_blk_addr;
				rd_addr = boot_rd_addr;
			end
			MNT_SCAN:
			begin
				blk_start = scan_blk_start;
				blk_addr = scan_blk_addr;
				rd_addr = scan_rd_addr;
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			state <= MNT_IDLE;
			boot_go <= 1'b0;
			scan_go <= 1'b0;
			clear <= 1'b0;
			mount_busy <= 1'b0;
			mount_done <= 1'b0;
			mount_err <= ERR_NONE;
		end
		else
		begin
			boot_go <= 1'b0;
			scan_go <= 1'b0;
			clear <= 1'b0;
			mount_done <= 1'b0;
			case (state)
				MNT_IDLE:
				begin
					if (mount_req)
					begin
						clear <= 1'b1;
						mount_busy <= 1'b1;
						state <= MNT_WAIT_CARD;
					end
				end
				MNT_WAIT_CARD:
				begin
					if (sd_idle)
					begin
						boot_go <= 1'b1;
						state <= MNT_BOOT;
					end
				end
				MNT_BOOT:
				begin
					if (boot_done)
					begin
						mount_err <= boot_err; // held until next mount
						if (boot_err != ERR_NONE)
						begin
							mount_done <= 1'b1;
							state <= MNT_REPORT;
						end
						else
						begin
							scan_go <= 1'b1;
							state <= MNT_SCAN;
						end
					end
				end
				MNT_SCAN:
				begin
					if (scan_done)
					begin
						mount_done <= 1'b1;
						state <= MNT_REPORT;
					end
				end
				MNT_REPORT:
				begin
					mount_busy <= 1'b0;
					state <= MNT_IDLE;
				end
				default: state <= MNT_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/fat_entry_out.sv
//********************
// entry output stage
// numbers accepted files and counts them
//********************
`default_nettype none

`include "fat_consts.svh"

module fat_entry_out (
	input  wire                  sys_clk,
	input  wire                  rst,
	input  logic                 clear,
	input  logic                 hit,
	input  fat_pkg::dir_entry_t  hit_entry,
	output logic                 entry_valid,
	output fat_pkg::dir_entry_t  entry,
	output logic                 full,
	output fat_pkg::file_count_t file_count
);
	import fat_pkg::*;

	assign full = (file_count == file_count_t'(`FAT_MAX_FILES));

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			entry_valid <= 1'b0;
			file_count <= '0;
		end
		else
		begin
			entry_valid <= hit;
			if (clear)
				file_count <= '0; // new mount
			else if (hit)
				file_count <= file_count + 5'd1;
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (hit)
		begin
			entry <= hit_entry;
			entry.idx <= file_idx_t'(file_count);
		end
	end

endmodule

`default_nettype wire

// File: design/fat_dir_scan.sv
//********************
// root directory scanner
// walks the root sectors slot by slot and reports regular files
//********************
`default_nettype none

`include "fat_consts.svh"

module fat_dir_scan (
	input  wire                  sys_clk,
	input  wire                  rst,
	input  logic                 go,
	input  fat_pkg::bpb_t        bpb,
	output fat_pkg::buf_addr_t   rd_addr,
	input  fat_pkg::byte_t       rd_data,
	output logic                 blk_start,
	output fat_pkg::block_addr_t blk_addr,
	input  logic                 blk_done,
	input  logic                 full,
	output logic                 hit,
	output fat_pkg::dir_entry_t  hit_entry,
	output logic                 scan_done
);
	import fat_pkg::*;

	scan_state_e  state;
	logic [4:0]   sector;
	logic [3:0]   slot;
	logic [4:0]   step;
	byte_t [17:0] raw;
	block_addr_t  root_base;
	buf_addr_t    slot_base;
	logic         attr_ok;

	// fetch order: first byte, attribute, rest of name, cluster, size
	function automatic buf_addr_t field_ofs(input logic [4:0] i);
		if (i == 5'd0)
			field_ofs = '0;
		else if (i == 5'd1)
			field_ofs = buf_addr_t'(`FAT_OFS_ATTR);
		else if (i < 5'd12)
			field_ofs = buf_addr_t'(i - 5'd1);
		else if (i < 5'd14)
			field_ofs = buf_addr_t'(`FAT_OFS_FIRST_CLUS + i - 12);
		else
			field_ofs = buf_addr_t'(`FAT_OFS_FILE_SIZE + i - 14);
	endfunction

	assign root_base = block_addr_t'(bpb.rsvd_sec_cnt) + block_addr_t'({bpb.fat_size, 1'b0});
	assign slot_base = buf_addr_t'(slot * `FAT_ENTRY_BYTES);
	assign attr_ok = (rd_data[5:0] != `FAT_ATTR_LONG_NAME)
		&& !rd_data[`FAT_ATTR_VOLUME_BIT] && !rd_data[`FAT_ATTR_DIR_BIT];
	assign hit_entry = '{
		idx:        '0, // stamped downstream
		name:       {raw[11:2], raw[0]},
		first_clus: {raw[13], raw[12]},
		size:       {raw[17:14]}
	};

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			state <= SCAN_IDLE;
			sector <= '0;
			slot <= '0;
			step <= '0;
			rd_addr <= '0;
			blk_start <= 1'b0;
			hit <= 1'b0;
			scan_done <= 1'b0;
		end
		else
		begin
			blk_start <= 1'b0;
			hit <= 1'b0;
			scan_done <= 1'b0;
			case (state)
				SCAN_IDLE:
				begin
					if (go)
					begin
						sector <= '0;
						slot <= '0;
						blk_start <= 1'b1;
						blk_addr <= root_base;
						state <= SCAN_READ;
					end
				end
				SCAN_READ:
				begin
					step <= '0;
					if (blk_done)
						state <= SCAN_FETCH;
				end
				SCAN_FETCH:
				begin
					step <= step + 5'd1;
					if (step < 5'd18)
						rd_addr <= slot_base + field_ofs(step);
					if (step == 5'd2 && rd_data == `FAT_ENTRY_END)
						state <= SCAN_END; // end of directory
					else if (step == 5'd2 && rd_data == `FAT_ENTRY_DELETED)
						state <= SCAN_NEXT;
					else if (step == 5'd3 && !attr_ok)
						state <= SCAN_NEXT;
					else if (step == 5'd19)
					begin
						hit <= 1'b1;
						state <= SCAN_HIT;
					end
				end
				SCAN_HIT: state <= SCAN_NEXT; // lets full settle
				SCAN_NEXT:
				begin
					step <= '0;
					if (full)
						state <= SCAN_END;
					else if (slot == 4'(`FAT_SECTOR_BYTES / `FAT_ENTRY_BYTES - 1))
					begin
						slot <= '0;
						if (sector == 5'(`FAT_ROOT_SECTORS - 1))
							state <= SCAN_END;
						else
						begin
							sector <= sector + 5'd1;
							blk_start <= 1'b1;
							blk_addr <= root_base + block_addr_t'(sector) + 32'd1;
							state <= SCAN_READ;
						end
					end
					else
					begin
						slot <= slot + 4'd1;
						state <= SCAN_FETCH;
					end
				end
				SCAN_END:
				begin
					scan_done <= 1'b1;
					state <= SCAN_IDLE;
				end
				default: state <= SCAN_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (state == SCAN_FETCH && step >= 5'd2)
			raw <= {rd_data, raw[17:1]};
	end

endmodule

`default_nettype wire

// File: design/fat_boot_decode.sv
//********************
// boot sector decoder
// reads the BPB fields of block 0 and checks the volume
//********************
`default_nettype none

`include "fat_consts.svh"

module fat_boot_decode (
	input  wire                  sys_clk,
	input  wire                  rst,
	input  logic                 go,
	output fat_pkg::buf_addr_t   rd_addr,
	input  fat_pkg::byte_t       rd_data,
	output logic                 blk_start,
	output fat_pkg::block_addr_t blk_addr,
	input  logic                 blk_done,
	output fat_pkg::bpb_t        bpb,
	output fat_pkg::mount_err_e  boot_err,
	output logic                 boot_done
);
	import fat_pkg::*;

	boot_state_e state;
	logic [3:0]  step;
	byte_t [8:0] raw;

	// byte offsets of the nine BPB bytes, in fetch order
	function automatic buf_addr_t boot_ofs(input logic [3:0] i);
		case (i)
			4'd0:    boot_ofs = buf_addr_t'(`FAT_OFS_BYTES_PER_SEC);
			4'd1:    boot_ofs = buf_addr_t'(`FAT_OFS_BYTES_PER_SEC + 1);
			4'd2:    boot_ofs = buf_addr_t'(`FAT_OFS_SEC_PER_CLUS);
			4'd3:    boot_ofs = buf_addr_t'(`FAT_OFS_RSVD_SEC);
			4'd4:    boot_ofs = buf_addr_t'(`FAT_OFS_RSVD_SEC + 1);
			4'd5:    boot_ofs = buf_addr_t'(`FAT_OFS_ROOT_ENT);
			4'd6:    boot_ofs = buf_addr_t'(`FAT_OFS_ROOT_ENT + 1);
			4'd7:    boot_ofs = buf_addr_t'(`FAT_OFS_FAT_SIZE);
			default: boot_ofs = buf_addr_t'(`FAT_OFS_FAT_SIZE + 1);
		endcase
	endfunction

	assign blk_addr = '0; // boot sector
	assign bpb = '{
		bytes_per_sec: {raw[1], raw[0]},
		sec_per_clus:  raw[2],
		rsvd_sec_cnt:  {raw[4], raw[3]},
		root_ent_cnt:  {raw[6], raw[5]},
		fat_size:      {raw[8], raw[7]}
	};

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			state <= BOOT_IDLE;
			step <= '0;
			rd_addr <= '0;
			blk_start <= 1'b0;
			boot_done <= 1'b0;
			boot_err <= ERR_NONE;
		end
		else
		begin
			blk_start <= 1'b0;
			boot_done <= 1'b0;
			case (state)
				BOOT_IDLE:
				begin
					if (go)
					begin
						blk_start <= 1'b1;
						state <= BOOT_READ;
					end
				end
				BOOT_READ:
				begin
					step <= '0;
					if (blk_done)
						state <= BOOT_FETCH;
				end
				BOOT_FETCH:
				begin
					if (step < 4'd9)
						rd_addr <= boot_ofs(step);
					if (step == 4'd10) // last byte lands now
						state <= BOOT_CHECK;
					else
						step <= step + 4'd1;
				end
				BOOT_CHECK:
				begin
					boot_done <= 1'b1;
					state <= BOOT_IDLE;
					if (bpb.bytes_per_sec != 16'(`FAT_SECTOR_BYTES))
						boot_err <= ERR_SECTOR_SIZE;
					else if (bpb.fat_size == '0)
						boot_err <= ERR_NOT_FAT16;
					else if (bpb.root_ent_cnt != 16'(`FAT_ROOT_ENTRIES))
						boot_err <= ERR_ROOT_SIZE;
					else
						boot_err <= ERR_NONE;
				end
				default: state <= BOOT_IDLE;
			endcase
		end
	end

	// data trails the address by two steps
	always_ff @(posedge sys_clk)
	begin
		if (state == BOOT_FETCH && step >= 4'd2)
			raw <= {rd_data, raw[8:1]};
	end

endmodule

`default_nettype wire

// File: design/fat_block_reader.sv
//********************
// SD block reader
// one request pulse, a short settle, then wait for card idle
//********************
`default_nettype none

module fat_block_reader (
	input  wire                 sys_clk,
	input  wire                 rst,
	input  logic                blk_start,
	input  fat_pkg::block_addr_t blk_addr,
	input  logic                sd_idle,
	output logic                block_req,
	output fat_pkg::block_addr_t block_addr,
	output logic                blk_done
);
	import fat_pkg::*;

	blk_state_e state;
	logic [1:0] settle_cnt;

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			state <= BLK_IDLE;
			settle_cnt <= '0;
			block_req <= 1'b0;
			blk_done <= 1'b0;
		end
		else
		begin
			block_req <= 1'b0;
			blk_done <= 1'b0;
			case (state)
				BLK_IDLE:
				begin
					if (blk_start)
					begin
						block_req <= 1'b1;
						block_addr <= blk_addr; // held for the card
						settle_cnt <= '0;
						state <= BLK_SETTLE;
					end
				end
				BLK_SETTLE:
				begin
					settle_cnt <= settle_cnt + 2'd1;
					if (settle_cnt == 2'd3) // req cycle plus 3
						state <= BLK_WAIT;
				end
				BLK_WAIT:
				begin
					if (sd_idle)
					begin
						blk_done <= 1'b1;
						state <= BLK_IDLE;
					end
				end
				default: state <= BLK_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/fat_pkg.sv
//********************
// FAT16 mount types
// vectors, boot and entry records, error codes and FSM states
//********************
`default_nettype none

`include "fat_consts.svh"

package fat_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [8:0]  buf_addr_t;
	typedef logic [31:0] block_addr_t;
	typedef logic [15:0] cluster_t;
	typedef logic [31:0] file_size_t;
	typedef logic [3:0]  file_idx_t;
	typedef logic [4:0]  file_count_t;

	typedef struct packed {
		logic [15:0] bytes_per_sec;
		byte_t       sec_per_clus;
		logic [15:0] rsvd_sec_cnt;
		logic [15:0] root_ent_cnt;
		logic [15:0] fat_size;
	} bpb_t;

	// name[0] is the first character of the 8.3 name
	typedef struct packed {
		file_idx_t                       idx;
		byte_t [`FAT_NAME_BYTES-1:0]     name;
		cluster_t                        first_clus;
		file_size_t                      size;
	} dir_entry_t;

	typedef enum logic [1:0] {
		ERR_NONE        = 2'd0,
		ERR_SECTOR_SIZE = 2'd1,
		ERR_NOT_FAT16   = 2'd2,
		ERR_ROOT_SIZE   = 2'd3
	} mount_err_e;

	typedef enum logic [2:0] {MNT_IDLE, MNT_WAIT_CARD, MNT_BOOT, MNT_SCAN, MNT_REPORT} mount_state_e;
	typedef enum logic [1:0] {BOOT_IDLE, BOOT_READ, BOOT_FETCH, BOOT_CHECK} boot_state_e;
	typedef enum logic [2:0] {
		SCAN_IDLE, SCAN_READ, SCAN_FETCH, SCAN_HIT, SCAN_NEXT, SCAN_END
	} scan_state_e;
	typedef enum logic [1:0] {BLK_IDLE, BLK_SETTLE, BLK_WAIT} blk_state_e;

endpackage

`default_nettype wire

// File: design/fat_consts.svh
//********************
// FAT16 mount constants
// boot sector offsets, directory entry layout and limits
//********************
`ifndef FAT_CONSTS_SVH
`define FAT_CONSTS_SVH

`define FAT_SECTOR_BYTES      512
`define FAT_OFS_BYTES_PER_SEC 11
`define FAT_OFS_SEC_PER_CLUS  13
`define FAT_OFS_RSVD_SEC      14
`define FAT_OFS_ROOT_ENT      17
`define FAT_OFS_FAT_SIZE      22

`define FAT_ENTRY_BYTES       32
`define FAT_OFS_ATTR          11
`define FAT_OFS_FIRST_CLUS    26
`define FAT_OFS_FILE_SIZE     28
`define FAT_NAME_BYTES        11

`define FAT_ENTRY_DELETED     8'hE5
`define FAT_ENTRY_END         8'h00
`define FAT_ATTR_LONG_NAME    6'h0F
`define FAT_ATTR_VOLUME_BIT   3
`define FAT_ATTR_DIR_BIT      4

`define FAT_ROOT_ENTRIES      512
`define FAT_ROOT_SECTORS      32
`define FAT_MAX_FILES         16

`endif
